/* src/cpu_pkg.sv */
package cpu_pkg;

    // Data, RAM address and program counter sizes
    localparam int DATA_BITS     = 8;
    localparam int MEM_ADDR_BITS = 8;
    localparam int PC_BITS       = 16;

    // Bus sources
    localparam int SET_DB_TO_ACC      = 0;
    localparam int SET_SB_TO_ACC      = 1;
    localparam int SET_SB_TO_X        = 2;
    localparam int SET_SB_TO_Y        = 3;
    localparam int SET_SB_TO_SP       = 4;
    localparam int SET_SB_TO_ALU      = 5;
    localparam int SET_DB_TO_SB       = 6;
    localparam int SET_DB_HIGH        = 7;
    // ALU inputs and operation
    localparam int SET_INPUT_A_TO_SB  = 8;
    localparam int SET_INPUT_A_TO_LOW = 9;
    localparam int SET_INPUT_B_TO_DB  = 10;
    localparam int SET_ALU_CARRY_HIGH = 11;
    localparam int ALU_ADD            = 12;
    localparam int ALU_ROT            = 13;
    localparam int ALU_SHR            = 14;
    localparam int ALU_ROR            = 15;
    localparam int LOAD_ALU           = 16;
    // Register writes
    localparam int LOAD_ACC           = 17;
    localparam int LOAD_X             = 18;
    localparam int LOAD_Y             = 19;
    localparam int LOAD_SP            = 20;
    localparam int SET_ACC_TO_SB      = 21;
    localparam int LOAD_CARRY         = 22;
    localparam int CARRY_SET          = 23;
    localparam int CARRY_CLR          = 24;
    // Program counter and address latches
    localparam int PC_INC             = 25;
    localparam int SET_ADH_TO_PCH     = 26;
    localparam int SET_ADL_TO_PCL     = 27;
    localparam int LOAD_ABH           = 28;
    localparam int LOAD_ABL           = 29;
    localparam int NUMFLAGS           = 30;

    // Implied-mode opcodes at their 6502 encodings
    typedef enum logic [7:0] {
        OP_BRK   = 8'h00,
        OP_ASL_A = 8'h0A,
        OP_CLC   = 8'h18,
        OP_ROL_A = 8'h2A,
        OP_SEC   = 8'h38,
        OP_LSR_A = 8'h4A,
        OP_ROR_A = 8'h6A,
        OP_DEY   = 8'h88,
        OP_TXA   = 8'h8A,
        OP_TYA   = 8'h98,
        OP_TXS   = 8'h9A,
        OP_TAY   = 8'hA8,
        OP_TAX   = 8'hAA,
        OP_TSX   = 8'hBA,
        OP_INY   = 8'hC8,
        OP_DEX   = 8'hCA,
        OP_INX   = 8'hE8,
        OP_NOP   = 8'hEA
    } opcode_e;

    typedef enum logic [2:0] {
        STEP_0 = 3'd0,
        STEP_1 = 3'd1
    } step_e;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_REQ,
        FETCH_REL,
        EXEC_0,
        EXEC_1,
        HALTED
    } seq_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ACCESS,
        ARB_ACK
    } arb_state_e;

endpackage

/* src/implied_decode.sv */
module implied_decode (
    input  cpu_pkg::opcode_e             opcode,
    input  cpu_pkg::step_e               step,
    input  logic                         carry,
    output logic [cpu_pkg::NUMFLAGS-1:0] flags
);
    import cpu_pkg::*;

    always_comb begin
        flags = '0;
        // Every instruction closes by stepping the PC onto the address latches
        if (step == STEP_1) begin
            flags[PC_INC]         = 1'b1;
            flags[SET_ADH_TO_PCH] = 1'b1;
            flags[SET_ADL_TO_PCL] = 1'b1;
            flags[LOAD_ABH]       = 1'b1;
            flags[LOAD_ABL]       = 1'b1;
        end
        case (opcode)
            OP_ASL_A, OP_ROL_A, OP_LSR_A, OP_ROR_A: begin
                case (step)
                    STEP_0: begin
                        flags[SET_SB_TO_ACC]      = 1'b1;
                        flags[SET_INPUT_A_TO_SB]  = 1'b1;
                        flags[SET_ALU_CARRY_HIGH] = (opcode inside {OP_ROL_A, OP_ROR_A}) && carry;
                        if (opcode inside {OP_ASL_A, OP_ROL_A}) begin
                            // Shift left as ACC + ACC
                            flags[SET_DB_TO_ACC]     = 1'b1;
                            flags[SET_INPUT_B_TO_DB] = 1'b1;
                            flags[ALU_ADD]           = 1'b1;
                        end else begin
                            flags[ALU_ROT] = 1'b1;
                            flags[ALU_SHR] = (opcode == OP_LSR_A);
                            flags[ALU_ROR] = (opcode == OP_ROR_A);
                        end
                        flags[LOAD_ALU] = 1'b1;
                    end
                    STEP_1: begin
                        // Result back to ACC, carry out to C
                        flags[SET_SB_TO_ALU] = 1'b1;
                        flags[SET_ACC_TO_SB] = 1'b1;
                        flags[LOAD_CARRY]    = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_INX, OP_INY, OP_DEX, OP_DEY: begin
                case (step)
                    STEP_0: begin
                        flags[SET_SB_TO_X]       = opcode inside {OP_INX, OP_DEX};
                        flags[SET_SB_TO_Y]       = opcode inside {OP_INY, OP_DEY};
                        flags[SET_INPUT_B_TO_DB] = 1'b1;
                        if (opcode inside {OP_INX, OP_INY}) begin
                            // 0 + reg with carry in
                            flags[SET_DB_TO_SB]       = 1'b1;
                            flags[SET_INPUT_A_TO_LOW] = 1'b1;
                            flags[SET_ALU_CARRY_HIGH] = 1'b1;
                        end else begin
                            // reg + FF
                            flags[SET_DB_HIGH]       = 1'b1;
                            flags[SET_INPUT_A_TO_SB] = 1'b1;
                        end
                        flags[ALU_ADD]  = 1'b1;
                        flags[LOAD_ALU] = 1'b1;
                    end
                    STEP_1: begin
                        flags[SET_SB_TO_ALU] = 1'b1;
                        flags[LOAD_X]        = opcode inside {OP_INX, OP_DEX};
                        flags[LOAD_Y]        = opcode inside {OP_INY, OP_DEY};
                    end
                    default: ;
                endcase
            end
            OP_TAX, OP_TAY, OP_TSX, OP_TXA, OP_TXS, OP_TYA: begin
                case (step)
                    STEP_0: begin
                        // Source straight over SB into the destination
                        flags[SET_SB_TO_ACC] = opcode inside {OP_TAX, OP_TAY};
                        flags[SET_SB_TO_X]   = opcode inside {OP_TXA, OP_TXS};
                        flags[SET_SB_TO_Y]   = (opcode == OP_TYA);
                        flags[SET_SB_TO_SP]  = (opcode == OP_TSX);
                        flags[LOAD_X]        = opcode inside {OP_TAX, OP_TSX};
                        flags[LOAD_Y]        = (opcode == OP_TAY);
                        flags[LOAD_ACC]      = opcode inside {OP_TXA, OP_TYA};
                        flags[LOAD_SP]       = (opcode == OP_TXS);
                    end
                    default: ;
                endcase
            end
            OP_SEC, OP_CLC: begin
                case (step)
                    STEP_0: begin
                        flags[CARRY_SET] = (opcode == OP_SEC);
                        flags[CARRY_CLR] = (opcode == OP_CLC);
                    end
                    default: ;
                endcase
            end
            // NOP, BRK and unknown bytes only advance the PC
            default: ;
        endcase
    end

endmodule

/* src/cycle_sequencer.sv */
module cycle_sequencer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    output logic                          fetch_req,
    input  logic                          fetch_ack,
    input  logic [cpu_pkg::DATA_BITS-1:0] fetch_data,
    output cpu_pkg::opcode_e              opcode,
    output cpu_pkg::step_e                step,
    output logic                          retire,
    output logic                          halted
);
    import cpu_pkg::*;

    seq_state_e state;
    opcode_e    opcode_q;

    // Bytes outside the supported set run as NOP
    function automatic opcode_e known_opcode(input logic [DATA_BITS-1:0] data_byte);
        case (data_byte)
            OP_BRK, OP_ASL_A, OP_CLC, OP_ROL_A, OP_SEC, OP_LSR_A, OP_ROR_A,
            OP_DEY, OP_TXA, OP_TYA, OP_TXS, OP_TAY, OP_TAX, OP_TSX,
            OP_INY, OP_DEX, OP_INX, OP_NOP:
                known_opcode = opcode_e'(data_byte);
            default:
                known_opcode = OP_NOP;
        endcase
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            opcode_q <= OP_NOP;
        end else begin
            case (state)
                IDLE: begin
                    if (run)
                        state <= FETCH_REQ;
                end
                FETCH_REQ: begin
                    // Read data is valid while ack is high
                    if (fetch_ack) begin
                        opcode_q <= known_opcode(fetch_data);
                        state    <= FETCH_REL;
                    end
                end
                FETCH_REL: begin
                    if (!fetch_ack)
                        state <= (opcode_q == OP_BRK) ? HALTED : EXEC_0;
                end
                EXEC_0: state <= EXEC_1;
                EXEC_1: state <= run ? FETCH_REQ : IDLE;
                HALTED: state <= HALTED;
                default: state <= IDLE;
            endcase
        end
    end

    assign fetch_req = (state == FETCH_REQ);
    assign retire    = (state == EXEC_1);
    assign halted    = (state == HALTED);

    // Decoder sees NOP step 0 outside execution, which drives no flags
    assign opcode = (state == EXEC_0 || state == EXEC_1) ? opcode_q : OP_NOP;
    assign step   = (state == EXEC_1) ? STEP_1 : STEP_0;

endmodule

/* src/alu_datapath.sv */
module alu_datapath (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [cpu_pkg::NUMFLAGS-1:0]      flags,
    output logic                              carry,
    output logic [cpu_pkg::MEM_ADDR_BITS-1:0] abl,
    output logic [cpu_pkg::DATA_BITS-1:0]     acc,
    output logic [cpu_pkg::DATA_BITS-1:0]     x_reg,
    output logic [cpu_pkg::DATA_BITS-1:0]     y_reg,
    output logic [cpu_pkg::DATA_BITS-1:0]     sp_reg,
    output logic [cpu_pkg::PC_BITS-1:0]       pc
);
    import cpu_pkg::*;

    logic [DATA_BITS-1:0]             sb;
    logic [DATA_BITS-1:0]             db;
    logic [DATA_BITS-1:0]             a_in;
    logic [DATA_BITS-1:0]             b_in;
    logic                             alu_cin;
    logic [DATA_BITS:0]               sum;
    logic [DATA_BITS-1:0]             alu_res;
    logic                             alu_cout;
    logic [DATA_BITS-1:0]             alu_q;
    logic                             alu_cout_q;
    logic [PC_BITS-1:0]               pc_next;
    logic [PC_BITS-MEM_ADDR_BITS-1:0] adh;
    logic [MEM_ADDR_BITS-1:0]         adl;
    logic [PC_BITS-MEM_ADDR_BITS-1:0] abh;

    // Stack bus and data bus
    always_comb begin
        if (flags[SET_SB_TO_ALU])
            sb = alu_q;
        else if (flags[SET_SB_TO_ACC])
            sb = acc;
        else if (flags[SET_SB_TO_X])
            sb = x_reg;
        else if (flags[SET_SB_TO_Y])
            sb = y_reg;
        else if (flags[SET_SB_TO_SP])
            sb = sp_reg;
        else
            sb = '0;

        if (flags[SET_DB_HIGH])
            db = '1;
        else if (flags[SET_DB_TO_ACC])
            db = acc;
        else if (flags[SET_DB_TO_SB])
            db = sb;
        else
            db = '0;
    end

    // ALU input latches
    assign a_in    = (flags[SET_INPUT_A_TO_SB] && !flags[SET_INPUT_A_TO_LOW]) ? sb : '0;
    assign b_in    = flags[SET_INPUT_B_TO_DB] ? db : '0;
    assign alu_cin = flags[SET_ALU_CARRY_HIGH];
    assign sum     = {1'b0, a_in} + {1'b0, b_in} + {{DATA_BITS{1'b0}}, alu_cin};

    always_comb begin
        alu_res  = a_in;
        alu_cout = 1'b0;
        if (flags[ALU_ADD])
            {alu_cout, alu_res} = sum;
        else if (flags[ALU_SHR])
            alu_res = {1'b0, a_in[DATA_BITS-1:1]};
        else if (flags[ALU_ROR])
            alu_res = {alu_cin, a_in[DATA_BITS-1:1]};
        // Right shifts push bit 0 out to carry
        if (flags[ALU_ROT])
            alu_cout = a_in[0];
    end

    always_ff @(posedge clk) begin
        if (flags[LOAD_ALU]) begin
            alu_q      <= alu_res;
            alu_cout_q <= alu_cout;
        end
    end

    // Address buses carry the incremented PC so the next fetch sees it
    assign pc_next = pc + {{(PC_BITS-1){1'b0}}, flags[PC_INC]};
    assign adh     = flags[SET_ADH_TO_PCH] ? pc_next[PC_BITS-1:MEM_ADDR_BITS] : '0;
    assign adl     = flags[SET_ADL_TO_PCL] ? pc_next[MEM_ADDR_BITS-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc    <= '0;
            x_reg  <= '0;
            y_reg  <= '0;
            sp_reg <= '1;
            carry  <= 1'b0;
            pc     <= '0;
            abh    <= '0;
            abl    <= '0;
        end else begin
            if (flags[LOAD_ACC] || flags[SET_ACC_TO_SB])
                acc <= sb;
            if (flags[LOAD_X])
                x_reg <= sb;
            if (flags[LOAD_Y])
                y_reg <= sb;
            if (flags[LOAD_SP])
                sp_reg <= sb;
            if (flags[CARRY_SET])
                carry <= 1'b1;
            else if (flags[CARRY_CLR])
                carry <= 1'b0;
            else if (flags[LOAD_CARRY])
                carry <= alu_cout_q;
            pc <= pc_next;
            if (flags[LOAD_ABH])
                abh <= adh;
            if (flags[LOAD_ABL])
                abl <= adl;
        end
    end

endmodule

/* src/mem_arbiter.sv */
module mem_arbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              host_req,
    input  logic                              host_we,
    input  logic [cpu_pkg::MEM_ADDR_BITS-1:0] host_addr,
    input  logic [cpu_pkg::DATA_BITS-1:0]     host_wdata,
    output logic                              host_ack,
    output logic [cpu_pkg::DATA_BITS-1:0]     host_rdata,
    input  logic                              fetch_req,
    input  logic [cpu_pkg::MEM_ADDR_BITS-1:0] fetch_addr,
    output logic                              fetch_ack,
    output logic [cpu_pkg::DATA_BITS-1:0]     fetch_data,
    output logic                              ram_en,
    output logic                              ram_we,
    output logic [cpu_pkg::MEM_ADDR_BITS-1:0] ram_addr,
    output logic [cpu_pkg::DATA_BITS-1:0]     ram_wdata,
    input  logic [cpu_pkg::DATA_BITS-1:0]     ram_rdata
);
    import cpu_pkg::*;

    arb_state_e state;
    logic       grant_host;
    logic       granted_req;

    assign granted_req = grant_host ? host_req : fetch_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ARB_IDLE;
            grant_host <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Host wins a tie
                    if (host_req) begin
                        grant_host <= 1'b1;
                        state      <= ARB_ACCESS;
                    end else if (fetch_req) begin
                        grant_host <= 1'b0;
                        state      <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: state <= ARB_ACK;
                ARB_ACK: begin
                    // Hold the grant until the owner releases req
                    if (!granted_req)
                        state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign ram_en    = (state == ARB_ACCESS);
    assign ram_we    = ram_en && grant_host && host_we;
    assign ram_addr  = grant_host ? host_addr : fetch_addr;
    assign ram_wdata = host_wdata;

    assign host_ack   = (state == ARB_ACK) && grant_host;
    assign fetch_ack  = (state == ARB_ACK) && !grant_host;
    assign host_rdata = grant_host ? ram_rdata : '0;
    assign fetch_data = grant_host ? '0 : ram_rdata;

endmodule

/* src/program_ram.sv */
module program_ram (
    input  logic                              clk,
    input  logic                              en,
    input  logic                              we,
    input  logic [cpu_pkg::MEM_ADDR_BITS-1:0] addr,
    input  logic [cpu_pkg::DATA_BITS-1:0]     wdata,
    output logic [cpu_pkg::DATA_BITS-1:0]     rdata
);
    import cpu_pkg::*;

    logic [DATA_BITS-1:0] mem [2**MEM_ADDR_BITS];

    // Registered read, old data on a write cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];
        end
    end

endmodule

/* src/implied_core_top.sv */
module implied_core_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              host_req,
    input  logic                              host_we,
    input  logic [cpu_pkg::MEM_ADDR_BITS-1:0] host_addr,
    input  logic [cpu_pkg::DATA_BITS-1:0]     host_wdata,
    output logic                              host_ack,
    output logic [cpu_pkg::DATA_BITS-1:0]     host_rdata,
    output logic                              retire,
    output logic                              halted,
    output logic [cpu_pkg::DATA_BITS-1:0]     acc,
    output logic [cpu_pkg::DATA_BITS-1:0]     x_reg,
    output logic [cpu_pkg::DATA_BITS-1:0]     y_reg,
    output logic [cpu_pkg::DATA_BITS-1:0]     sp_reg,
    output logic                              carry,
    output logic [cpu_pkg::PC_BITS-1:0]       pc
);
    import cpu_pkg::*;

    logic [NUMFLAGS-1:0]      flags;
    opcode_e                  opcode;
    step_e                    step;
    logic                     fetch_req;
    logic                     fetch_ack;
    logic [DATA_BITS-1:0]     fetch_data;
    logic [MEM_ADDR_BITS-1:0] abl;
    logic                     ram_en;
    logic                     ram_we;
    logic [MEM_ADDR_BITS-1:0] ram_addr;
    logic [DATA_BITS-1:0]     ram_wdata;
    logic [DATA_BITS-1:0]     ram_rdata;

    cycle_sequencer u_cycle_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .fetch_req  (fetch_req),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .opcode     (opcode),
        .step       (step),
        .retire     (retire),
        .halted     (halted)
    );

    implied_decode u_implied_decode (
        .opcode (opcode),
        .step   (step),
        .carry  (carry),
        .flags  (flags)
    );

    alu_datapath u_alu_datapath (
        .clk    (clk),
        .rst_n  (rst_n),
        .flags  (flags),
        .carry  (carry),
        .abl    (abl),
        .acc    (acc),
        .x_reg  (x_reg),
        .y_reg  (y_reg),
        .sp_reg (sp_reg),
        .pc     (pc)
    );

    // Fetch address comes from ABL
    mem_arbiter u_mem_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .fetch_req  (fetch_req),
        .fetch_addr (abl),
        .fetch_ack  (fetch_ack),
        .fetch_data (fetch_data),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata)
    );

    program_ram u_program_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* bench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0;
int checks_done = 0;

task automatic check_byte(input logic [DATA_BITS-1:0] got,
                          input logic [DATA_BITS-1:0] exp,
                          input string what);
    checks_done++;
    if (got !== exp) begin
        error_count++;
        $display("ERR %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
endtask

// Carry and status bits
task automatic check_bit(input logic got, input logic exp, input string what);
    checks_done++;
    if (got !== exp) begin
        error_count++;
        $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

task automatic check_pc(input logic [PC_BITS-1:0] got,
                        input logic [PC_BITS-1:0] exp,
                        input string what);
    checks_done++;
    if (got !== exp) begin
        error_count++;
        $display("ERR %0t: %s is %04h, expected %04h", $time, what, got, exp);
    end
endtask

task automatic check_retires(input int got, input int exp, input string what);
    checks_done++;
    if (got != exp) begin
        error_count++;
        $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
endtask

`endif

/* bench/tb_implied_core.sv */
module tb_implied_core;
    import cpu_pkg::*;

    `include "tb_checks.svh"

    localparam int ACK_TIMEOUT  = 50;
    localparam int HALT_TIMEOUT = 2000;

    logic                     clk;
    logic                     rst_n;
    logic                     run;
    logic                     host_req;
    logic                     host_we;
    logic [MEM_ADDR_BITS-1:0] host_addr;
    logic [DATA_BITS-1:0]     host_wdata;
    logic                     host_ack;
    logic [DATA_BITS-1:0]     host_rdata;
    logic                     retire;
    logic                     halted;
    logic [DATA_BITS-1:0]     acc;
    logic [DATA_BITS-1:0]     x_reg;
    logic [DATA_BITS-1:0]     y_reg;
    logic [DATA_BITS-1:0]     sp_reg;
    logic                     carry;
    logic [PC_BITS-1:0]       pc;

    integer seed;
    int     retire_count;

    // Program image and architectural model
    logic [DATA_BITS-1:0] prog [$];
    logic [DATA_BITS-1:0] m_a;
    logic [DATA_BITS-1:0] m_x;
    logic [DATA_BITS-1:0] m_y;
    logic [DATA_BITS-1:0] m_sp;
    logic                 m_c;
    logic [PC_BITS-1:0]   m_pc;

    implied_core_top u_implied_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_ack   (host_ack),
        .host_rdata (host_rdata),
        .retire     (retire),
        .halted     (halted),
        .acc        (acc),
        .x_reg      (x_reg),
        .y_reg      (y_reg),
        .sp_reg     (sp_reg),
        .carry      (carry),
        .pc         (pc)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            retire_count <= 0;
        else if (retire)
            retire_count <= retire_count + 1;
    end

    // Inputs change and outputs are sampled 5 units after the rising edge
    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks: %0d, errors: %0d", checks_done, error_count);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic apply_reset();
        rst_n    = 1'b0;
        run      = 1'b0;
        host_req = 1'b0;
        host_we  = 1'b0;
        repeat (10) tick();
        rst_n = 1'b1;
        tick();
    endtask

    task automatic wait_host_ack(input logic level);
        int waited = 0;
        while (host_ack !== level) begin
            tick();
            waited++;
            if (waited > ACK_TIMEOUT)
                abort_run("Host port handshake got no response from the DUT");
        end
    endtask

    task automatic host_write(input logic [MEM_ADDR_BITS-1:0] addr,
                              input logic [DATA_BITS-1:0] data);
        host_addr  = addr;
        host_wdata = data;
        host_we    = 1'b1;
        host_req   = 1'b1;
        wait_host_ack(1'b1);
        host_req = 1'b0;
        wait_host_ack(1'b0);
        host_we = 1'b0;
    endtask

    task automatic host_read(input logic [MEM_ADDR_BITS-1:0] addr,
                             output logic [DATA_BITS-1:0] data);
        host_addr = addr;
        host_we   = 1'b0;
        host_req  = 1'b1;
        wait_host_ack(1'b1);
        // Read data is only valid while ack is high
        data     = host_rdata;
        host_req = 1'b0;
        wait_host_ack(1'b0);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++)
            host_write(MEM_ADDR_BITS'(i), prog[i]);
    endtask

    task automatic wait_halted();
        int waited = 0;
        while (!halted) begin
            tick();
            waited++;
            if (waited > HALT_TIMEOUT)
                abort_run("Core never reached the halted state");
        end
        run = 1'b0;
    endtask

    task automatic model_exec(input logic [DATA_BITS-1:0] op);
        case (op)
            OP_ASL_A: begin
                m_c = m_a[7];
                m_a = m_a << 1;
            end
            OP_ROL_A: {m_c, m_a} = {m_a, m_c};
            OP_LSR_A: begin
                m_c = m_a[0];
                m_a = m_a >> 1;
            end
            OP_ROR_A: {m_a, m_c} = {m_c, m_a};
            OP_INX: m_x = m_x + 8'd1;
            OP_INY: m_y = m_y + 8'd1;
            OP_DEX: m_x = m_x - 8'd1;
            OP_DEY: m_y = m_y - 8'd1;
            OP_TAX: m_x = m_a;
            OP_TAY: m_y = m_a;
            OP_TSX: m_x = m_sp;
            OP_TXA: m_a = m_x;
            OP_TXS: m_sp = m_x;
            OP_TYA: m_a = m_y;
            OP_SEC: m_c = 1'b1;
            OP_CLC: m_c = 1'b0;
            default: ;
        endcase
        m_pc = m_pc + 16'd1;
    endtask

    // BRK ends the program without retiring
    task automatic model_program();
        m_a  = '0;
        m_x  = '0;
        m_y  = '0;
        m_sp = 8'hFF;
        m_c  = 1'b0;
        m_pc = '0;
        for (int i = 0; i < prog.size(); i++) begin
            if (prog[i] == OP_BRK)
                break;
            model_exec(prog[i]);
        end
    endtask

    task automatic check_core_state(input string tag);
        check_byte(acc, m_a, {tag, " A"});
        check_byte(x_reg, m_x, {tag, " X"});
        check_byte(y_reg, m_y, {tag, " Y"});
        check_byte(sp_reg, m_sp, {tag, " SP"});
        check_bit(carry, m_c, {tag, " carry"});
        check_pc(pc, m_pc, {tag, " PC"});
        check_retires(retire_count, int'(m_pc), {tag, " retire count"});
    endtask

    task automatic test_host_port();
        logic [DATA_BITS-1:0]     shadow [2**MEM_ADDR_BITS];
        bit                       written [2**MEM_ADDR_BITS];
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]     data;
        for (int i = 0; i < 24; i++) begin
            addr = $random(seed);
            data = $random(seed);
            host_write(addr, data);
            shadow[addr]  = data;
            written[addr] = 1'b1;
        end
        for (int a = 0; a < 2**MEM_ADDR_BITS; a++) begin
            if (written[a]) begin
                host_read(MEM_ADDR_BITS'(a), data);
                check_byte(data, shadow[a], "host read-back");
            end
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        check_byte(acc, 8'h00, "reset A");
        check_byte(x_reg, 8'h00, "reset X");
        check_byte(y_reg, 8'h00, "reset Y");
        check_byte(sp_reg, 8'hFF, "reset SP");
        check_bit(carry, 1'b0, "reset carry");
        check_pc(pc, 16'h0000, "reset PC");
        check_bit(retire, 1'b0, "reset retire");
        check_bit(halted, 1'b0, "reset halted");
        check_bit(host_ack, 1'b0, "reset host_ack");
        check_bit(u_implied_core_top.fetch_req, 1'b0, "reset fetch_req");
    endtask

    task automatic build_count_program();
        prog = {OP_INX, OP_INX, OP_DEY, OP_TXA, OP_TAY, OP_TSX, OP_TXS, OP_DEX, OP_BRK};
    endtask

    task automatic test_inc_dec_transfer();
        apply_reset();
        build_count_program();
        load_program();
        model_program();
        run = 1'b1;
        wait_halted();
        check_core_state("count program");
        check_retires(retire_count, 8, "count program retires");
    endtask

    task automatic test_shift_rotate();
        int len;
        int pick;
        apply_reset();
        // Seed A with FE so both ends shift ones
        prog = {OP_SEC, OP_DEX, OP_DEX, OP_TXA};
        len  = 10 + ($unsigned($random(seed)) % 8);
        for (int i = 0; i < len; i++) begin
            pick = $unsigned($random(seed)) % 6;
            case (pick)
                0: prog.push_back(OP_ASL_A);
                1: prog.push_back(OP_ROL_A);
                2: prog.push_back(OP_LSR_A);
                3: prog.push_back(OP_ROR_A);
                4: begin
                    prog.push_back(OP_INX);
                    prog.push_back(OP_TXA);
                end
                default: prog.push_back(OP_CLC);
            endcase
        end
        prog.push_back(OP_BRK);
        load_program();
        model_program();
        run = 1'b1;
        wait_halted();
        check_core_state("shift program");
    endtask

    task automatic test_contention();
        logic [DATA_BITS-1:0] data;
        int                   addr;
        int                   reads = 0;
        apply_reset();
        build_count_program();
        load_program();
        model_program();
        run = 1'b1;
        while (!halted) begin
            addr = $unsigned($random(seed)) % prog.size();
            host_read(MEM_ADDR_BITS'(addr), data);
            check_byte(data, prog[addr], "host read under contention");
            reads++;
            if (reads > 300)
                abort_run("Core did not halt while the host was reading RAM");
            // One idle arbiter cycle so a pending fetch can take the RAM
            tick();
        end
        wait_halted();
        check_core_state("contention");
        check_retires(retire_count, 8, "contention retires");
    endtask

    task automatic test_unknown_and_run();
        logic [PC_BITS-1:0] pc_hold;
        int                 count_hold;
        int                 waited = 0;
        apply_reset();
        prog = {8'h02, OP_INX, 8'hFF, 8'h44, OP_NOP, 8'h7B, OP_INY, 8'h12, OP_BRK};
        load_program();
        model_program();
        repeat (20) tick();
        check_pc(pc, 16'h0000, "PC with run low");
        check_retires(retire_count, 0, "retires with run low");
        run = 1'b1;
        while (retire_count < 3) begin
            tick();
            waited++;
            if (waited > HALT_TIMEOUT)
                abort_run("Core retired nothing after run was raised");
        end
        run = 1'b0;
        // Let the instruction in flight drain
        repeat (10) tick();
        pc_hold    = pc;
        count_hold = retire_count;
        repeat (20) tick();
        check_pc(pc, pc_hold, "PC held while run is low");
        check_retires(retire_count, count_hold, "retires held while run is low");
        // Fourth fetch was already under way when run fell
        check_pc(pc, 16'h0004, "PC at pause");
        check_retires(count_hold, 4, "retires at pause");
        run = 1'b1;
        wait_halted();
        check_core_state("unknown opcodes");
    endtask

    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        seed       = 32'h562a;
        apply_reset();
        test_host_port();
        test_reset_state();
        test_inc_dec_transfer();
        test_shift_rotate();
        test_contention();
        test_unknown_and_run();
        $display("Checks: %0d, errors: %0d", checks_done, error_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
src/cpu_pkg.sv
src/implied_decode.sv
src/cycle_sequencer.sv
src/alu_datapath.sv
src/mem_arbiter.sv
src/program_ram.sv
src/implied_core_top.sv
bench/tb_implied_core.sv
